// File: design/sprite_settings.svh
// Sprite attribute table settings
// Table geometry, entry field layout, sprite height and the
// AXI4-Lite address map shared by the packages and the RTL

`ifndef SPRITE_SETTINGS_SVH
`define SPRITE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// table geometry
`define SPRITE_COUNT   32
`define SPRITE_IDX_W   5

// entry fields, pad bits 31:28 stay zero
`define SPRITE_X_W     10
`define SPRITE_Y_W     9
`define SPRITE_OFS_W   9
`define SPRITE_OFS_LSB 0
`define SPRITE_Y_LSB   9
`define SPRITE_X_LSB   18

`define SPRITE_LINES   20   // sprite height in lines

////////////////////////////////////////////////////////////
// bus and address map
`define AXIL_ADDR_W    12
`define AXIL_DATA_W    32
`define AXIL_IDX_LSB   2    // entry index at addr 6:2
`define AXIL_SEL_LSB   7    // field select at addr 8:7
`define AXIL_SEL_W     2

`endif

// File: design/bus_pkg.sv
// AXI4-Lite bus types
// Request and response channel bundles for the host port
// and the write/read response code

`include "sprite_settings.svh"

package bus_pkg;

	// response code, only the two the slave returns
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axil_resp_e;

	////////////////////////////////////////////////////////////
	// master side, all five channels
	typedef struct packed {
		logic                      awvalid;
		logic [`AXIL_ADDR_W-1:0]   awaddr;
		logic                      wvalid;
		logic [`AXIL_DATA_W-1:0]   wdata;
		logic [`AXIL_DATA_W/8-1:0] wstrb;   // not used by this slave
		logic                      bready;
		logic                      arvalid;
		logic [`AXIL_ADDR_W-1:0]   araddr;
		logic                      rready;
	} axil_req_t;

	// slave side
	typedef struct packed {
		logic                    awready;
		logic                    wready;
		logic                    bvalid;
		axil_resp_e              bresp;
		logic                    arready;
		logic                    rvalid;
		logic [`AXIL_DATA_W-1:0] rdata;
		axil_resp_e              rresp;
	} axil_rsp_t;

endpackage

// File: design/sprite_pkg.sv
// Sprite table types
// Entry layout, field select codes, the field write command
// and the lookup query and result bundles

`include "sprite_settings.svh"

package sprite_pkg;

	////////////////////////////////////////////////////////////
	// one table entry, matches the 32-bit bus word
	typedef struct packed {
		logic [3:0]               pad;      // always zero
		logic [`SPRITE_X_W-1:0]   x;        // bits 27:18
		logic [`SPRITE_Y_W-1:0]   y;        // bits 17:9
		logic [`SPRITE_OFS_W-1:0] offset;   // bits 8:0
	} sprite_entry_t;

	// field select, code 3 is not a field
	typedef enum logic [`AXIL_SEL_W-1:0] {
		fld_offset = 2'd0,
		fld_y      = 2'd1,
		fld_x      = 2'd2
	} sprite_field_e;

	// single field update from the bus
	typedef struct packed {
		logic                     valid;
		logic [`SPRITE_IDX_W-1:0] idx;
		sprite_field_e            field;
		sprite_entry_t            value;    // only the selected field counts
	} field_write_t;

	////////////////////////////////////////////////////////////
	// pixel side lookup
	typedef struct packed {
		logic                   valid;
		logic [`SPRITE_X_W-1:0] x;
		logic [`SPRITE_Y_W-1:0] y;
	} match_query_t;

	typedef struct packed {
		logic                     valid;
		logic                     hit;
		logic [`SPRITE_IDX_W-1:0] idx;      // lowest matching entry
		logic [`SPRITE_OFS_W-1:0] offset;
	} match_result_t;

endpackage

// File: design/axi_lite_slave.sv
// AXI4-Lite slave for the sprite attribute table
// Writes update one field of one entry, selected by address bits.
// Reads return a whole entry. Select code 3 answers SLVERR.

`include "sprite_settings.svh"

module axi_lite_slave (
	input  logic                      clk,
	input  logic                      rst_n,
	input  bus_pkg::axil_req_t        req,
	output bus_pkg::axil_rsp_t        rsp,
	output sprite_pkg::field_write_t  wr_cmd,
	output logic [`SPRITE_IDX_W-1:0]  rd_idx,
	input  sprite_pkg::sprite_entry_t rd_entry
);

	logic                    wr_hs;      // aw and w taken together
	logic                    rd_hs;
	logic [`AXIL_SEL_W-1:0]  wr_sel;
	logic                    sel_ok;

	logic                    bvalid_q;
	bus_pkg::axil_resp_e     bresp_q;
	logic                    rvalid_q;
	logic [`AXIL_DATA_W-1:0] rdata_q;

	////////////////////////////////////////////////////////////
	// write channel

	// both address and data must be there, and the last
	// response must be gone
	assign wr_hs  = req.awvalid && req.wvalid && !bvalid_q;
	assign wr_sel = req.awaddr[`AXIL_SEL_LSB +: `AXIL_SEL_W];
	assign sel_ok = wr_sel inside {sprite_pkg::fld_offset, sprite_pkg::fld_y,
		sprite_pkg::fld_x};

	// field command goes to the table on the handshake edge
	assign wr_cmd.valid = wr_hs && sel_ok;   // select 3 writes nothing
	assign wr_cmd.idx   = req.awaddr[`AXIL_IDX_LSB +: `SPRITE_IDX_W];
	assign wr_cmd.field = sprite_pkg::sprite_field_e'(wr_sel);
	assign wr_cmd.value = sprite_pkg::sprite_entry_t'(req.wdata);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid_q <= 1'b0;
		end else if (wr_hs) begin
			bvalid_q <= 1'b1;
		end else if (req.bready) begin
			bvalid_q <= 1'b0;   // response taken
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bresp_q <= sel_ok ? bus_pkg::resp_okay : bus_pkg::resp_slverr;
		end
	end

	////////////////////////////////////////////////////////////
	// read channel

	assign rd_hs  = req.arvalid && !rvalid_q;
	assign rd_idx = req.araddr[`AXIL_IDX_LSB +: `SPRITE_IDX_W];   // select bits ignored

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid_q <= 1'b0;
		end else if (rd_hs) begin
			rvalid_q <= 1'b1;
		end else if (req.rready) begin
			rvalid_q <= 1'b0;
		end
	end

	// data held stable while rvalid waits for rready
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata_q <= rd_entry;
		end
	end

	////////////////////////////////////////////////////////////
	// response bundle

	assign rsp.awready = wr_hs;
	assign rsp.wready  = wr_hs;
	assign rsp.bvalid  = bvalid_q;
	assign rsp.bresp   = bresp_q;
	assign rsp.arready = rd_hs;
	assign rsp.rvalid  = rvalid_q;
	assign rsp.rdata   = rdata_q;
	assign rsp.rresp   = bus_pkg::resp_okay;   // every entry is readable

endmodule

// File: design/sprite_table.sv
// Sprite attribute storage
// 32 entries of x, y and pattern offset. A field write updates
// only the named field and keeps the rest of the entry.
// One combinational read port, all entries out to the matcher.

`include "sprite_settings.svh"

module sprite_table (
	input  logic                      clk,
	input  logic                      rst_n,
	input  sprite_pkg::field_write_t  wr_cmd,
	input  logic [`SPRITE_IDX_W-1:0]  rd_idx,
	output sprite_pkg::sprite_entry_t rd_entry,
	output sprite_pkg::sprite_entry_t entries [`SPRITE_COUNT]
);

	////////////////////////////////////////////////////////////
	// storage and field update

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `SPRITE_COUNT; i++) begin
				entries[i] <= '0;   // x 0, y 0, offset 0
			end
		end else if (wr_cmd.valid) begin
			// pad bits are never written so they stay zero
			case (wr_cmd.field)
				sprite_pkg::fld_offset: begin
					entries[wr_cmd.idx].offset <= wr_cmd.value.offset;
				end
				sprite_pkg::fld_y: begin
					entries[wr_cmd.idx].y <= wr_cmd.value.y;
				end
				sprite_pkg::fld_x: begin
					entries[wr_cmd.idx].x <= wr_cmd.value.x;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// bus read port

	assign rd_entry = entries[rd_idx];   // sees writes from the edge before

endmodule

// File: design/sprite_match.sv
// Sprite coordinate matcher
// Compares a pixel query against every entry: x must be equal
// and y must fall within the sprite height from the entry's y.
// The lowest matching entry wins; the result is registered.

`include "sprite_settings.svh"

module sprite_match (
	input  logic                       clk,
	input  logic                       rst_n,
	input  sprite_pkg::sprite_entry_t  entries [`SPRITE_COUNT],
	input  sprite_pkg::match_query_t   query,
	output sprite_pkg::match_result_t  result
);

	localparam int unsigned Y_EXT_W = `SPRITE_Y_W + 1;   // bound must not wrap
	localparam int unsigned IDX_W   = `SPRITE_IDX_W;

	logic [`SPRITE_COUNT-1:0] in_box;
	logic                     hit_any;
	logic [IDX_W-1:0]         hit_idx;
	logic [`SPRITE_OFS_W-1:0] hit_ofs;

	////////////////////////////////////////////////////////////
	// per entry comparators

	for (genvar g = 0; g < `SPRITE_COUNT; g++) begin : g_cmp
		logic [Y_EXT_W-1:0] y_end;   // first line below the sprite

		assign y_end = {1'b0, entries[g].y} + Y_EXT_W'(`SPRITE_LINES);
		assign in_box[g] = (query.x == entries[g].x) &&
			(query.y >= entries[g].y) &&
			({1'b0, query.y} < y_end);
	end

	////////////////////////////////////////////////////////////
	// priority pick

	// walk down so the lowest index is the last one kept
	always_comb begin
		hit_any = 1'b0;
		hit_idx = '0;
		hit_ofs = '0;
		for (int i = `SPRITE_COUNT - 1; i >= 0; i--) begin
			if (in_box[i]) begin
				hit_any = 1'b1;
				hit_idx = IDX_W'(i);
				hit_ofs = entries[i].offset;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else begin
			result.valid  <= query.valid;
			result.hit    <= query.valid && hit_any;
			result.idx    <= query.valid ? hit_idx : '0;   // zero on a miss
			result.offset <= query.valid ? hit_ofs : '0;
		end
	end

endmodule

// File: design/sprite_regfile_top.sv
// Sprite attribute register file, top level
// Host access over AXI4-Lite, pixel side lookup with a
// one cycle registered match result

`include "sprite_settings.svh"

module sprite_regfile_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  bus_pkg::axil_req_t        axil_req,
	output bus_pkg::axil_rsp_t        axil_rsp,
	input  sprite_pkg::match_query_t  query,
	output sprite_pkg::match_result_t result
);

	sprite_pkg::field_write_t  wr_cmd;
	logic [`SPRITE_IDX_W-1:0]  rd_idx;
	sprite_pkg::sprite_entry_t rd_entry;
	sprite_pkg::sprite_entry_t entries [`SPRITE_COUNT];   // full table to matcher

	////////////////////////////////////////////////////////////
	// host side

	axi_lite_slave u_slave (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (axil_req),
		.rsp      (axil_rsp),
		.wr_cmd   (wr_cmd),
		.rd_idx   (rd_idx),
		.rd_entry (rd_entry)
	);

	sprite_table u_table (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr_cmd   (wr_cmd),
		.rd_idx   (rd_idx),
		.rd_entry (rd_entry),
		.entries  (entries)
	);

	////////////////////////////////////////////////////////////
	// pixel side

	sprite_match u_match (
		.clk     (clk),
		.rst_n   (rst_n),
		.entries (entries),
		.query   (query),
		.result  (result)
	);

endmodule

// File: dv/sprite_regfile_tb.sv
// Testbench for the sprite attribute register file
// Runs a table of bus writes, reads and lookups against the DUT
// and checks them with a shadow model of the 32 entries

`include "sprite_settings.svh"

module sprite_regfile_tb;

	typedef enum logic [2:0] {
		op_write, op_read, op_lookup, op_burst, op_stall_wr, op_stall_rd
	} op_e;

	// exp holds bresp, an entry word or {hit, idx, offset}
	typedef struct packed {
		op_e         op;
		logic [4:0]  idx;
		logic [1:0]  sel;
		logic [31:0] data;   // write word or query x and y in entry layout
		logic [7:0]  n;      // stall cycles or burst length
		logic [31:0] exp;
	} row_t;

	logic                      clk = 1'b0;
	logic                      rst_n;
	bus_pkg::axil_req_t        axil_req;
	bus_pkg::axil_rsp_t        axil_rsp;
	sprite_pkg::match_query_t  query;
	sprite_pkg::match_result_t result;

	row_t        rows [$];
	logic [31:0] shadow [`SPRITE_COUNT];
	int          seed = 32'hdf28_2604;
	int          cycles = 0;
	int          max_cycles = 0;
	int          value_errs = 0;
	int          proto_errs = 0;

	sprite_regfile_top i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.query    (query),
		.result   (result)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (max_cycles != 0 && cycles >= max_cycles) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// word builders and shadow model

	function automatic logic [31:0] entry_word(input int x, input int y, input int ofs);
		logic [31:0] w;
		w = '0;
		w[`SPRITE_X_LSB +: `SPRITE_X_W]     = x[`SPRITE_X_W-1:0];
		w[`SPRITE_Y_LSB +: `SPRITE_Y_W]     = y[`SPRITE_Y_W-1:0];
		w[`SPRITE_OFS_LSB +: `SPRITE_OFS_W] = ofs[`SPRITE_OFS_W-1:0];
		return w;
	endfunction

	function automatic logic [31:0] lookup_word(input int hit, input int idx, input int ofs);
		return {17'b0, hit[0], idx[4:0], ofs[8:0]};
	endfunction

	function automatic logic [`AXIL_ADDR_W-1:0] addr_of(input logic [4:0] idx,
		input logic [1:0] sel);
		logic [`AXIL_ADDR_W-1:0] a;
		a = '0;
		a[`AXIL_IDX_LSB +: `SPRITE_IDX_W] = idx;
		a[`AXIL_SEL_LSB +: `AXIL_SEL_W]   = sel;
		return a;
	endfunction

	// only the selected field changes and the pad stays zero
	task automatic store_field(input logic [4:0] idx, input logic [1:0] sel,
		input logic [31:0] data);
		logic [31:0] mask;
		case (sel)
			2'd0: mask = entry_word(0, 0, -1);
			2'd1: mask = entry_word(0, -1, 0);
			2'd2: mask = entry_word(-1, 0, 0);
			default: mask = '0;
		endcase
		shadow[idx] = (shadow[idx] & ~mask) | (data & mask);
	endtask

	// lowest entry with equal x and y in [entry y, entry y + height)
	function automatic logic [31:0] model_lookup(input logic [31:0] q);
		int qx, qy, ex, ey;
		qx = q[`SPRITE_X_LSB +: `SPRITE_X_W];
		qy = q[`SPRITE_Y_LSB +: `SPRITE_Y_W];
		for (int i = 0; i < `SPRITE_COUNT; i++) begin
			ex = shadow[i][`SPRITE_X_LSB +: `SPRITE_X_W];
			ey = shadow[i][`SPRITE_Y_LSB +: `SPRITE_Y_W];
			if (qx == ex && qy >= ey && qy < ey + `SPRITE_LINES) begin
				return lookup_word(1, i, shadow[i][`SPRITE_OFS_LSB +: `SPRITE_OFS_W]);
			end
		end
		return '0;
	endfunction

	// query near a random entry so that hits and misses both show up
	function automatic logic [31:0] random_query();
		int r, e, x, y;
		r = $random(seed);
		e = r & 31;
		x = shadow[e][`SPRITE_X_LSB +: `SPRITE_X_W] + ((r >> 5) & 3) - 1;
		y = shadow[e][`SPRITE_Y_LSB +: `SPRITE_Y_W] + ((r >> 8) % 24) - 2;
		return entry_word(x, y, 0);
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		value_errs++;
		$display("FAILED %s expected %h got %h at cycle %0d", name, exp, got, cycles);
	endtask

	task automatic report_protocol(input string what);
		proto_errs++;
		$display("error at cycle %0d: %s", cycles, what);
	endtask

	////////////////////////////////////////////////////////////
	// bus and lookup drivers

	task automatic next_cycle();
		@(posedge clk);
		#1;   // inputs change just after the edge
	endtask

	task automatic bus_write(input logic [4:0] idx, input logic [1:0] sel,
		input logic [31:0] data);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr  = addr_of(idx, sel);
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = data;
		#2;
		while (!(axil_rsp.awready && axil_rsp.wready)) begin
			next_cycle();
			#2;
		end
		next_cycle();
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		store_field(idx, sel, data);
	endtask

	task automatic wait_bresp(output logic [1:0] resp);
		while (!axil_rsp.bvalid) next_cycle();
		resp = axil_rsp.bresp;
		next_cycle();
	endtask

	task automatic bus_read(input logic [4:0] idx, input logic [1:0] sel);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr_of(idx, sel);
		#2;
		while (!axil_rsp.arready) begin
			next_cycle();
			#2;
		end
		next_cycle();
		axil_req.arvalid = 1'b0;
	endtask

	task automatic wait_rdata(output logic [31:0] data);
		while (!axil_rsp.rvalid) next_cycle();
		data = axil_rsp.rdata;
		if (axil_rsp.rresp !== bus_pkg::resp_okay) begin
			report_value("rresp", bus_pkg::resp_okay, axil_rsp.rresp);
		end
		next_cycle();
	endtask

	// result must be there exactly one edge after the query
	task automatic lookup(input logic [31:0] q, input logic [31:0] exp);
		logic [31:0] got;
		query.valid = 1'b1;
		query.x     = q[`SPRITE_X_LSB +: `SPRITE_X_W];
		query.y     = q[`SPRITE_Y_LSB +: `SPRITE_Y_W];
		next_cycle();
		got = {17'b0, result.hit, result.idx, result.offset};
		if (!result.valid) report_protocol("no lookup result one cycle after the query");
		if (got !== exp) report_value("result {hit, idx, offset}", exp, got);
	endtask

	task automatic stalled_write(input row_t r);
		logic [1:0] resp;
		axil_req.bready = 1'b0;
		bus_write(r.idx, sprite_pkg::fld_x, r.data);
		axil_req.awvalid = 1'b1;   // second write waits behind the response
		axil_req.awaddr  = addr_of(r.idx, sprite_pkg::fld_offset);
		axil_req.wvalid  = 1'b1;
		axil_req.wdata   = r.data;
		for (int k = 0; k < r.n; k++) begin
			#2;
			if (!axil_rsp.bvalid) report_protocol("bvalid dropped while bready was low");
			if (axil_rsp.awready || axil_rsp.wready) begin
				report_protocol("second write accepted before the response was taken");
			end
			next_cycle();
		end
		if (axil_rsp.bresp !== bus_pkg::resp_okay) begin
			report_value("bresp", bus_pkg::resp_okay, axil_rsp.bresp);
		end
		axil_req.bready = 1'b1;
		bus_write(r.idx, sprite_pkg::fld_offset, r.data);
		wait_bresp(resp);
		if (resp !== bus_pkg::resp_okay) report_value("bresp", bus_pkg::resp_okay, resp);
	endtask

	task automatic stalled_read(input row_t r);
		logic [4:0]  next_idx;
		logic [31:0] data;
		next_idx = r.idx + 5'd1;
		axil_req.rready = 1'b0;
		bus_read(r.idx, 2'd0);
		axil_req.arvalid = 1'b1;
		axil_req.araddr  = addr_of(next_idx, 2'd0);
		for (int k = 0; k < r.n; k++) begin
			#2;
			if (!axil_rsp.rvalid) report_protocol("rvalid dropped while rready was low");
			if (axil_rsp.arready) report_protocol("second read accepted before data was taken");
			if (axil_rsp.rdata !== shadow[r.idx]) begin
				report_value("rdata", shadow[r.idx], axil_rsp.rdata);
			end
			next_cycle();
		end
		axil_req.rready = 1'b1;
		bus_read(next_idx, 2'd0);
		wait_rdata(data);
		if (data !== shadow[next_idx]) report_value("rdata", shadow[next_idx], data);
	endtask

	////////////////////////////////////////////////////////////
	// operation table

	task automatic push_row(input op_e op, input logic [4:0] idx, input logic [1:0] sel,
		input logic [31:0] data, input logic [7:0] n, input logic [31:0] exp);
		row_t r;
		r.op   = op;
		r.idx  = idx;
		r.sel  = sel;
		r.data = data;
		r.n    = n;
		r.exp  = exp;
		rows.push_back(r);
	endtask

	task automatic build_table();
		for (int i = 0; i < `SPRITE_COUNT; i++) begin
			push_row(op_read, i[4:0], i[1:0], 0, 0, 0);   // select bits vary and are ignored
		end
		push_row(op_lookup, 0, 0, entry_word(0, 5, 0), 1, lookup_word(1, 0, 0));
		// entry 3 built up one field at a time
		push_row(op_write, 3, 2, entry_word(100, 0, 0), 0, bus_pkg::resp_okay);
		push_row(op_read, 3, 0, 0, 0, entry_word(100, 0, 0));
		push_row(op_write, 3, 1, entry_word(0, 50, 0), 0, bus_pkg::resp_okay);
		push_row(op_read, 3, 0, 0, 0, entry_word(100, 50, 0));
		push_row(op_write, 3, 0, entry_word(0, 0, 'h1a5), 0, bus_pkg::resp_okay);
		push_row(op_read, 3, 1, 0, 0, entry_word(100, 50, 'h1a5));
		push_row(op_write, 3, 1, entry_word('h3ff, 60, 'h1ff) | 32'hf000_0000, 0,
			bus_pkg::resp_okay);   // junk outside y
		push_row(op_read, 3, 0, 0, 0, entry_word(100, 60, 'h1a5));
		push_row(op_write, 3, 1, entry_word(0, 50, 0), 0, bus_pkg::resp_okay);
		push_row(op_write, 3, 3, 32'hffff_ffff, 0, bus_pkg::resp_slverr);
		push_row(op_read, 3, 0, 0, 0, entry_word(100, 50, 'h1a5));
		// y range edges and x neighbours
		push_row(op_lookup, 0, 0, entry_word(100, 50, 0), 1, lookup_word(1, 3, 'h1a5));
		push_row(op_lookup, 0, 0, entry_word(100, 69, 0), 1, lookup_word(1, 3, 'h1a5));
		push_row(op_lookup, 0, 0, entry_word(100, 49, 0), 1, 0);
		push_row(op_lookup, 0, 0, entry_word(100, 70, 0), 1, 0);
		push_row(op_lookup, 0, 0, entry_word(99, 55, 0), 1, 0);
		push_row(op_lookup, 0, 0, entry_word(101, 55, 0), 1, 0);
		// overlapping sprites on the same column
		push_row(op_write, 7, 2, entry_word(100, 0, 0), 0, bus_pkg::resp_okay);
		push_row(op_write, 7, 1, entry_word(0, 40, 0), 0, bus_pkg::resp_okay);
		push_row(op_write, 7, 0, entry_word(0, 0, 'h007), 0, bus_pkg::resp_okay);
		push_row(op_write, 2, 2, entry_word(100, 0, 0), 0, bus_pkg::resp_okay);
		push_row(op_write, 2, 1, entry_word(0, 60, 0), 0, bus_pkg::resp_okay);
		push_row(op_write, 2, 0, entry_word(0, 0, 'h022), 0, bus_pkg::resp_okay);
		push_row(op_lookup, 0, 0, entry_word(100, 45, 0), 1, lookup_word(1, 7, 'h007));
		push_row(op_lookup, 0, 0, entry_word(100, 55, 0), 1, lookup_word(1, 3, 'h1a5));
		push_row(op_lookup, 0, 0, entry_word(100, 65, 0), 1, lookup_word(1, 2, 'h022));
		push_row(op_lookup, 0, 0, entry_word(100, 79, 0), 1, lookup_word(1, 2, 'h022));
		// sprite whose lines run past y 511
		push_row(op_write, 9, 2, entry_word('h3ff, 0, 0), 0, bus_pkg::resp_okay);
		push_row(op_write, 9, 1, entry_word(0, 'h1f0, 0), 0, bus_pkg::resp_okay);
		push_row(op_write, 9, 0, entry_word(0, 0, 'h1ff), 0, bus_pkg::resp_okay);
		push_row(op_lookup, 0, 0, entry_word('h3ff, 'h1ff, 0), 1, lookup_word(1, 9, 'h1ff));
		push_row(op_lookup, 0, 0, entry_word('h3ff, 'h003, 0), 1, 0);
		push_row(op_burst, 0, 0, 0, 16, 0);
		push_row(op_burst, 0, 0, 0, 16, 0);
		push_row(op_stall_wr, 12, 0, entry_word(321, 200, 'h0bc), 5, 0);
		push_row(op_stall_rd, 12, 0, 0, 4, 0);
		push_row(op_burst, 0, 0, 0, 16, 0);
	endtask

	task automatic run_row(input row_t r);
		logic [1:0]  resp;
		logic [31:0] data;
		case (r.op)
			op_write: begin
				bus_write(r.idx, r.sel, r.data);
				wait_bresp(resp);
				if (resp !== r.exp[1:0]) report_value("bresp", r.exp, resp);
			end
			op_read: begin
				bus_read(r.idx, r.sel);
				wait_rdata(data);
				if (data !== r.exp) report_value("rdata", r.exp, data);
			end
			op_lookup: lookup(r.data, r.exp);
			op_burst: begin
				for (int k = 0; k < r.n; k++) begin
					data = random_query();   // back to back at one per cycle
					lookup(data, model_lookup(data));
				end
			end
			op_stall_wr: stalled_write(r);
			op_stall_rd: stalled_read(r);
			default: report_protocol("unknown operation in the table");
		endcase
		if (r.op == op_lookup || r.op == op_burst) begin
			query.valid = 1'b0;
			next_cycle();
			if (result.valid) report_protocol("lookup result valid without a query");
		end
	endtask

	initial begin
		rst_n    = 1'b0;
		axil_req = '0;
		axil_req.wstrb  = 4'hf;
		axil_req.bready = 1'b1;
		axil_req.rready = 1'b1;
		query    = '0;
		foreach (shadow[i]) shadow[i] = '0;
		build_table();
		max_cycles = rows.size() * 20;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		if (axil_rsp.bvalid || axil_rsp.rvalid || axil_rsp.arready || result.valid) begin
			report_protocol("bus or lookup outputs not cleared by reset");
		end
		foreach (rows[i]) run_row(rows[i]);
		$display("rows: %0d, value errors: %0d, protocol errors: %0d",
			rows.size(), value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+design
design/bus_pkg.sv
design/sprite_pkg.sv
design/axi_lite_slave.sv
design/sprite_table.sv
design/sprite_match.sv
design/sprite_regfile_top.sv
dv/sprite_regfile_tb.sv
